// File: Bender.yml
package:
  name: alpha_ctrl

export_include_dirs:
  - include

sources:
  - verilog/alpha_pkg.sv
  - verilog/alpha_command_decode.sv
  - verilog/alpha_bias_loader.sv
  - verilog/alpha_pulse_sequencer.sv
  - verilog/alpha_readout.sv
  - verilog/alpha_top.sv
  - target: simulation
    files:
      - dv/clock_gen.sv
      - dv/alpha_top_tb.sv

// File: dv/alpha_top_tb.sv
/* command table and serial readout table run side by side
   schedule timing comes from alpha_cfg.svh
   readout is checked for word order only */
`timescale 1ns/10ps
`include "alpha_cfg.svh"

module alpha_top_tb;
	import alpha_pkg::*;

	localparam int T = `ALPHA_STEP_CYCLES;
	localparam int C = `ALPHA_CONVERSION_CYCLES;
	localparam int S = `ALPHA_SERIAL_CYCLES;
	localparam int NCMD = 5;
	localparam int NRD = 8;
	localparam int IDLE = 24;
	// a full bias load plus handshake slack bounds one command
	localparam int LONGEST = 4 * 81 * S + 5 * T + C + 16;
	localparam int LIMIT = 5 + IDLE + NCMD * LONGEST + 16 * (NRD + 4);
	localparam int I_DRESET = 0;
	localparam int I_SYNC = 1;
	localparam int I_TRIG = 2;
	localparam int I_TOK = 3;
	localparam int I_SCLK = 4;
	localparam int I_PCLK = 5;

	logic clock, reset;
	logic cmd_req;
	alpha_op_t cmd_op;
	logic cmd_ack, cmd_bad;
	logic [11:0] cmp_bias, isel, sb_bias, db_bias;
	logic dreset, sync, trig_top, tok_a_in, sin, sclk, pclk;
	logic data_a;
	logic [15:0] data_word;
	logic header, word_valid;

	// commands, bias values per address and the expected cmd_bad
	alpha_op_t cmd_ops [NCMD] = '{OP_RESET_SYNC, OP_LOAD_BIAS, OP_TRIGGER, OP_UNDEFINED,
		OP_LOAD_BIAS};
	logic [11:0] cmd_bias [NCMD][4] = '{
		'{12'h000, 12'h000, 12'h000, 12'h000},
		'{12'h123, 12'h456, 12'h789, 12'habc},
		'{12'h000, 12'h000, 12'h000, 12'h000},
		'{12'h000, 12'h000, 12'h000, 12'h000},
		'{12'hfff, 12'h000, 12'h5a5, 12'ha5a}
	};
	logic cmd_bad_exp [NCMD] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0};

	// serial words in send order with the expected header flag
	logic [15:0] rd_words [NRD] = '{`ALPHA_HEADER_WORD, 16'h1234, 16'h5a5a, 16'h0c30,
		`ALPHA_HEADER_WORD, 16'h4924, 16'h9249, 16'h6666};
	logic rd_hdr [NRD] = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};

	string out_names [7] = '{"dreset", "sync", "trig_top", "tok_a_in", "sclk", "pclk", "sin"};
	int errors = 0;
	int checks = 0;
	int cycle = 0;
	int rd_seen = 0;
	int rises [7];
	int rise_at [7];
	int width [7];
	logic [6:0] prev_out = '0;
	logic [15:0] shift_word;
	int shift_bits = 0;
	logic [15:0] load_words [$];
	logic pclk_sin [$];
	int pclk_bits [$];

	clock_gen clocks (.clock(clock), .reset(reset));

	alpha_top uut (
		.clock(clock), .reset(reset), .cmd_req(cmd_req), .cmd_op(cmd_op),
		.cmd_ack(cmd_ack), .cmd_bad(cmd_bad), .cmp_bias(cmp_bias), .isel(isel),
		.sb_bias(sb_bias), .db_bias(db_bias), .dreset(dreset), .sync(sync),
		.trig_top(trig_top), .tok_a_in(tok_a_in), .sin(sin), .sclk(sclk), .pclk(pclk),
		.data_a(data_a), .data_word(data_word), .header(header), .word_valid(word_valid)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// true if the header pattern shows up anywhere but at the very end
	function automatic bit header_inside(input logic [47:0] seq);
		for (int j = 1; j <= 32; j++) begin
			if (seq[j +: 16] == `ALPHA_HEADER_WORD) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	task automatic report_counts();
		$display("checks %0d, errors %0d", checks, errors);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		checks++;
		assert (got === expected) else begin
			errors++;
			$display("ERROR %0t %s got 'h%0h expected 'h%0h", $time, name, got, expected);
		end
	endtask

	task automatic check_quiet();
		check_value("cmd_ack", cmd_ack, 0);
		check_value("cmd_bad", cmd_bad, 0);
		check_value("word_valid", word_valid, 0);
		check_value("header", header, 0);
		check_value("{sin,pclk,sclk,tok_a_in,trig_top,sync,dreset}",
			{sin, pclk, sclk, tok_a_in, trig_top, sync, dreset}, 0);
	endtask

	task automatic check_pulse(input int i);
		check_value({out_names[i], " pulse count"}, rises[i], 1);
		check_value({out_names[i], " width"}, width[i], T);
	endtask

	task automatic check_silent(input logic [6:0] mask);
		for (int i = 0; i < 7; i++) begin
			if (mask[i]) begin
				check_value({out_names[i], " rising edges"}, rises[i], 0);
			end
		end
	endtask

	task automatic clear_monitors();
		for (int i = 0; i < 7; i++) begin
			rises[i] = 0;
			rise_at[i] = 0;
			width[i] = 0;
		end
		shift_bits = 0;
		load_words.delete();
		pclk_sin.delete();
		pclk_bits.delete();
	endtask

	task automatic check_engines(input alpha_op_t op, input int idx);
		logic [15:0] expected;
		case (op)
			OP_RESET_SYNC: begin
				check_silent(7'b1111100);
				check_pulse(I_DRESET);
				check_pulse(I_SYNC);
				check_value("sync rise after dreset rise",
					rise_at[I_SYNC] - rise_at[I_DRESET], 2 * T);
			end
			OP_TRIGGER: begin
				check_silent(7'b1110011);
				check_pulse(I_TRIG);
				check_pulse(I_TOK);
				check_value("tok_a_in rise after trig_top rise",
					rise_at[I_TOK] - rise_at[I_TRIG], 2 * T + C);
			end
			OP_LOAD_BIAS: begin
				check_silent(7'b0001111);
				check_value("sclk rising edges", rises[I_SCLK], 64);
				check_value("rebuilt word count", load_words.size(), 4);
				for (int w = 0; w < 4 && w < load_words.size(); w++) begin
					// two zero bits, address, value
					expected = {2'b00, 2'(w), cmd_bias[idx][w]};
					check_value("sin word", load_words[w], expected);
				end
				check_value("pclk pulse count", pclk_sin.size(), 8);
				for (int p = 0; p < pclk_sin.size(); p++) begin
					check_value("sin at pclk rise", pclk_sin[p], p % 2);
					check_value("bits shifted before pclk", pclk_bits[p], 16 * (p / 2 + 1));
				end
			end
			default: begin
				check_silent(7'b1111111);
			end
		endcase
	endtask

	task automatic run_command(input int idx);
		alpha_op_t op;
		op = cmd_ops[idx];
		@(negedge clock);
		clear_monitors();
		@(posedge clock);
		cmd_op <= op;
		cmp_bias <= cmd_bias[idx][0];
		isel <= cmd_bias[idx][1];
		sb_bias <= cmd_bias[idx][2];
		db_bias <= cmd_bias[idx][3];
		@(posedge clock);
		cmd_req <= 1'b1;
		@(posedge clock);
		while (!cmd_ack) begin
			@(posedge clock);
		end
		check_value("cmd_bad", cmd_bad, cmd_bad_exp[idx]);
		cmd_req <= 1'b0;
		@(posedge clock);
		while (cmd_ack) begin
			@(posedge clock);
		end
		@(posedge clock);
		check_engines(op, idx);
	endtask

	task automatic send_word(input logic [15:0] w);
		for (int b = 15; b >= 0; b--) begin
			@(posedge clock);
			data_a <= w[b];
		end
	endtask

	task automatic send_stream();
		logic [31:0] seed;
		seed = xorshift32(32'hcf08);
		// filler must not form a header with the zeros before or the header after
		while (header_inside({16'h0000, seed[15:0], `ALPHA_HEADER_WORD})) begin
			seed = xorshift32(seed);
		end
		send_word(seed[15:0]);
		for (int i = 0; i < NRD; i++) begin
			send_word(rd_words[i]);
		end
		@(posedge clock);
		data_a <= 1'b0;
	endtask

	// engine output edges, shifted words and sin at each latch
	always @(posedge clock) begin : watch_outputs
		logic [6:0] cur;
		cur = {sin, pclk, sclk, tok_a_in, trig_top, sync, dreset};
		for (int i = 0; i < 7; i++) begin
			if (cur[i] && !prev_out[i]) begin
				rises[i]++;
				rise_at[i] = cycle;
			end
			if (!cur[i] && prev_out[i]) begin
				width[i] = cycle - rise_at[i];
			end
		end
		if (cur[I_SCLK] && !prev_out[I_SCLK]) begin
			shift_word = {shift_word[14:0], sin};
			shift_bits++;
			if (shift_bits % 16 == 0) begin
				load_words.push_back(shift_word);
			end
		end
		if (cur[I_PCLK] && !prev_out[I_PCLK]) begin
			pclk_sin.push_back(sin);
			pclk_bits.push_back(shift_bits);
		end
		prev_out = cur;
		cycle++;
		if (cycle >= LIMIT) begin
			$display("the run did not finish within %0d cycles", LIMIT);
			report_counts();
			$display("Something failed");
			$finish;
		end
	end

	// readout words are compared with the table in order
	// idle words after the table are not checked
	always @(posedge clock) begin
		if (!reset && word_valid) begin
			if (rd_seen < NRD) begin
				check_value("data_word", data_word, rd_words[rd_seen]);
				check_value("header", header, rd_hdr[rd_seen]);
			end
			rd_seen++;
		end
	end

	initial begin
		cmd_req = 1'b0;
		cmd_op = OP_RESET_SYNC;
		cmp_bias = '0;
		isel = '0;
		sb_bias = '0;
		db_bias = '0;
		data_a = 1'b0;
		@(negedge reset);
		repeat (IDLE) begin
			@(posedge clock);
			check_quiet();
		end
		fork
			begin
				for (int i = 0; i < NCMD; i++) begin
					run_command(i);
				end
			end
			send_stream();
		join
		while (rd_seen < NRD) begin
			@(posedge clock);
		end
		report_counts();
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end
endmodule

// File: dv/clock_gen.sv
/* free-running testbench clock with a 40 ns period
   reset is high for the first 5 rising edges */
`timescale 1ns/10ps

module clock_gen (
	output logic clock,
	output logic reset
);
	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (5) @(posedge clock);
		reset <= 1'b0;
	end
endmodule

// File: include/alpha_cfg.svh
/* timing constants in clock cycles, small values for simulation
   step and serial step must be at least 2 cycles */

`ifndef ALPHA_CFG_SVH
`define ALPHA_CFG_SVH

// unit step of the reset/sync and trigger/token schedules
`define ALPHA_STEP_CYCLES 4

// adc conversion wait between trig_top and tok_a_in
`define ALPHA_CONVERSION_CYCLES 16

// unit step of the bias shift, one bit takes three of these
`define ALPHA_SERIAL_CYCLES 2

// readout alignment word
`define ALPHA_HEADER_WORD 16'ha1fa

`endif

// File: sim.f
+incdir+include
verilog/alpha_pkg.sv
verilog/alpha_command_decode.sv
verilog/alpha_bias_loader.sv
verilog/alpha_pulse_sequencer.sv
verilog/alpha_readout.sv
verilog/alpha_top.sv
dv/clock_gen.sv
dv/alpha_top_tb.sv

// File: verilog/alpha_bias_loader.sv
/* bias values are captured at load_start and may change afterwards
   a load takes 4 x 81 serial steps; a new start restarts it */
`timescale 1ns/10ps
`include "alpha_cfg.svh"

module alpha_bias_loader (
	input  logic clock,
	input  logic reset,
	input  logic load_start,
	input  logic [11:0] cmp_bias,
	input  logic [11:0] isel,
	input  logic [11:0] sb_bias,
	input  logic [11:0] db_bias,
	output logic load_busy,
	output logic sin,
	output logic sclk,
	output logic pclk
);
	localparam int S = `ALPHA_SERIAL_CYCLES;
	localparam int SW = $clog2(S + 1);

	logic [11:0] bias_q [4];
	logic [SW-1:0] step_count;
	logic [6:0] phase;
	logic [6:0] next_phase;
	logic [6:0] bit_base;
	logic [3:0] bit_count;
	logic [1:0] word_count;
	logic [15:0] cur_word;
	logic tick;

	// phase counts serial steps inside one word
	assign tick = (step_count == SW'(S - 1));
	assign next_phase = phase + 7'd1;
	assign bit_base = 7'(3 * bit_count);
	// two zero bits, address, 12-bit value
	assign cur_word = {2'b00, word_count, bias_q[word_count]};

	always_ff @(posedge clock) begin
		if (load_start) begin
			bias_q[0] <= cmp_bias;
			bias_q[1] <= isel;
			bias_q[2] <= sb_bias;
			bias_q[3] <= db_bias;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			load_busy <= 1'b0;
			sin <= 1'b0;
			sclk <= 1'b0;
			pclk <= 1'b0;
			step_count <= '0;
			phase <= '0;
			bit_count <= '0;
			word_count <= '0;
		end else if (load_start) begin
			load_busy <= 1'b1;
			sin <= 1'b0;
			sclk <= 1'b0;
			pclk <= 1'b0;
			step_count <= SW'(1);
			phase <= '0;
			bit_count <= '0;
			word_count <= '0;
		end else if (load_busy) begin
			if (!tick) begin
				step_count <= step_count + 1'b1;
			end else begin
				step_count <= '0;
				phase <= next_phase;
				if (next_phase <= 7'd48) begin
					// three steps per bit, msb first
					if (next_phase == bit_base + 7'd1) begin
						sin <= cur_word[4'd15 - bit_count];
					end else if (next_phase == bit_base + 7'd2) begin
						sclk <= 1'b1;
					end else if (next_phase == bit_base + 7'd3) begin
						sclk <= 1'b0;
						bit_count <= bit_count + 1'b1;
					end
				end else begin
					// two latch pulses, sin low then high
					case (next_phase)
						7'd49: sin <= 1'b0;
						7'd50: pclk <= 1'b1;
						7'd63: pclk <= 1'b0;
						7'd64: sin <= 1'b1;
						7'd65: pclk <= 1'b1;
						7'd78: pclk <= 1'b0;
						7'd79: sin <= 1'b0;
						7'd81: begin
							if (word_count == 2'd3) begin
								load_busy <= 1'b0;
							end else begin
								word_count <= word_count + 1'b1;
								phase <= '0;
								bit_count <= '0;
							end
						end
						default: begin
						end
					endcase
				end
			end
		end
	end

endmodule

// File: verilog/alpha_command_decode.sv
/* one command at a time, cmd_op must hold while cmd_req is high
   undefined ops start nothing and are acked with cmd_bad set */
`timescale 1ns/10ps

module alpha_command_decode (
	input  logic clock,
	input  logic reset,
	input  logic cmd_req,
	input  alpha_pkg::alpha_op_t cmd_op,
	input  logic load_busy,
	input  logic seq_busy,
	output logic cmd_ack,
	output logic cmd_bad,
	output logic load_start,
	output logic seq_start,
	output alpha_pkg::pulse_kind_t seq_kind
);
	import alpha_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_WAIT_BUSY, S_ACK, S_RELEASE} state_t;

	state_t state;
	alpha_op_t op_q;
	logic armed;
	logic engine_busy;

	assign engine_busy = (op_q == OP_LOAD_BIAS) ? load_busy : seq_busy;
	assign seq_kind = (op_q == OP_TRIGGER) ? SCHED_TRIGGER : SCHED_RESET_SYNC;

	always_ff @(posedge clock) begin
		if (state == S_IDLE && cmd_req) begin
			op_q <= cmd_op;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= S_IDLE;
			armed <= 1'b0;
			cmd_ack <= 1'b0;
			cmd_bad <= 1'b0;
			load_start <= 1'b0;
			seq_start <= 1'b0;
		end else begin
			load_start <= 1'b0;
			seq_start <= 1'b0;
			case (state)
				S_IDLE: begin
					if (cmd_req && cmd_op == OP_UNDEFINED) begin
						cmd_ack <= 1'b1;
						cmd_bad <= 1'b1;
						state <= S_ACK;
					end else if (cmd_req) begin
						load_start <= (cmd_op == OP_LOAD_BIAS);
						seq_start <= (cmd_op != OP_LOAD_BIAS);
						armed <= 1'b0;
						state <= S_WAIT_BUSY;
					end
				end
				S_WAIT_BUSY: begin
					// skip the cycle before busy rises
					armed <= 1'b1;
					if (armed && !engine_busy) begin
						cmd_ack <= 1'b1;
						cmd_bad <= 1'b0;
						state <= S_ACK;
					end
				end
				S_ACK: begin
					if (!cmd_req) begin
						cmd_ack <= 1'b0;
						cmd_bad <= 1'b0;
						state <= S_RELEASE;
					end
				end
				S_RELEASE: begin
					// req and ack both low here for a cycle
					if (!cmd_req) begin
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// File: verilog/alpha_pkg.sv
/* command and schedule encodings shared by the decoder, engines and top */

package alpha_pkg;

	// host command ops, value 3 is rejected
	typedef enum logic [1:0] {
		OP_RESET_SYNC = 2'd0,
		OP_LOAD_BIAS  = 2'd1,
		OP_TRIGGER    = 2'd2,
		OP_UNDEFINED  = 2'd3
	} alpha_op_t;

	// which pulse schedule the sequencer plays
	typedef enum logic {
		SCHED_RESET_SYNC = 1'b0,
		SCHED_TRIGGER    = 1'b1
	} pulse_kind_t;

endpackage

// File: verilog/alpha_pulse_sequencer.sv
/* step T and conversion wait C from alpha_cfg.svh, T at least 2
   a start while busy restarts the schedule from the beginning */
`timescale 1ns/10ps
`include "alpha_cfg.svh"

module alpha_pulse_sequencer (
	input  logic clock,
	input  logic reset,
	input  logic seq_start,
	input  alpha_pkg::pulse_kind_t seq_kind,
	output logic seq_busy,
	output logic dreset,
	output logic sync,
	output logic trig_top,
	output logic tok_a_in
);
	import alpha_pkg::*;

	localparam int T = `ALPHA_STEP_CYCLES;
	localparam int C = `ALPHA_CONVERSION_CYCLES;
	localparam int CW = $clog2(5 * T + C + 2);

	pulse_kind_t kind_q;
	logic [CW-1:0] count;
	logic [CW-1:0] next_count;
	logic [CW-1:0] delay;
	logic first_on;
	logic second_on;
	logic is_trigger;

	// count is the cycle index since start
	assign next_count = count + 1'b1;
	assign is_trigger = (kind_q == SCHED_TRIGGER);
	// only the token waits for conversion
	assign delay = is_trigger ? CW'(C) : '0;
	assign first_on = (next_count >= CW'(T)) && (next_count < CW'(2 * T));
	assign second_on = (next_count >= CW'(3 * T) + delay) && (next_count < CW'(4 * T) + delay);

	always_ff @(posedge clock) begin
		if (seq_start) begin
			kind_q <= seq_kind;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			seq_busy <= 1'b0;
			count <= '0;
			dreset <= 1'b0;
			sync <= 1'b0;
			trig_top <= 1'b0;
			tok_a_in <= 1'b0;
		end else if (seq_start) begin
			seq_busy <= 1'b1;
			count <= CW'(1);
			dreset <= 1'b0;
			sync <= 1'b0;
			trig_top <= 1'b0;
			tok_a_in <= 1'b0;
		end else if (seq_busy) begin
			count <= next_count;
			seq_busy <= (next_count < CW'(5 * T) + delay);
			dreset <= first_on && !is_trigger;
			trig_top <= first_on && is_trigger;
			sync <= second_on && !is_trigger;
			tok_a_in <= second_on && is_trigger;
		end
	end

endmodule

// File: verilog/alpha_readout.sv
/* data_a is asynchronous; no words are reported before the first header
   a data word equal to the header realigns framing, as a header would */
`timescale 1ns/10ps
`include "alpha_cfg.svh"

module alpha_readout (
	input  logic clock,
	input  logic reset,
	input  logic data_a,
	output logic [15:0] data_word,
	output logic header,
	output logic word_valid
);
	logic [2:0] sync_q;
	logic [15:0] window;
	logic [3:0] bit_count;
	logic aligned;
	logic header_seen;
	logic word_done;

	assign header_seen = (window == `ALPHA_HEADER_WORD);
	// a full word lands every 16 bits after the header
	assign word_done = aligned && (bit_count == 4'd0);

	// three flops against metastability, then the 16-bit window
	always_ff @(posedge clock) begin
		sync_q <= {sync_q[1:0], data_a};
		window <= {window[14:0], sync_q[2]};
	end

	always_ff @(posedge clock) begin
		if (header_seen || word_done) begin
			data_word <= window;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			bit_count <= '0;
			aligned <= 1'b0;
			word_valid <= 1'b0;
			header <= 1'b0;
		end else begin
			bit_count <= bit_count + 1'b1;
			word_valid <= 1'b0;
			header <= 1'b0;
			if (header_seen) begin
				bit_count <= 4'd1;
				aligned <= 1'b1;
				word_valid <= 1'b1;
				header <= 1'b1;
			end else if (word_done) begin
				word_valid <= 1'b1;
			end
		end
	end

endmodule

// File: verilog/alpha_top.sv
/* host commands over a four-phase req/ack handshake, one at a time
   readout runs on its own and has no back-pressure */
`timescale 1ns/10ps

module alpha_top (
	input  logic clock,
	input  logic reset,
	input  logic cmd_req,
	input  alpha_pkg::alpha_op_t cmd_op,
	output logic cmd_ack,
	output logic cmd_bad,
	input  logic [11:0] cmp_bias,
	input  logic [11:0] isel,
	input  logic [11:0] sb_bias,
	input  logic [11:0] db_bias,
	output logic dreset,
	output logic sync,
	output logic trig_top,
	output logic tok_a_in,
	output logic sin,
	output logic sclk,
	output logic pclk,
	input  logic data_a,
	output logic [15:0] data_word,
	output logic header,
	output logic word_valid
);
	import alpha_pkg::*;

	logic load_start;
	logic load_busy;
	logic seq_start;
	logic seq_busy;
	pulse_kind_t seq_kind;

	alpha_command_decode decode (
		.clock(clock), .reset(reset), .cmd_req(cmd_req), .cmd_op(cmd_op),
		.load_busy(load_busy), .seq_busy(seq_busy), .cmd_ack(cmd_ack), .cmd_bad(cmd_bad),
		.load_start(load_start), .seq_start(seq_start), .seq_kind(seq_kind)
	);

	alpha_bias_loader loader (
		.clock(clock), .reset(reset), .load_start(load_start),
		.cmp_bias(cmp_bias), .isel(isel), .sb_bias(sb_bias), .db_bias(db_bias),
		.load_busy(load_busy), .sin(sin), .sclk(sclk), .pclk(pclk)
	);

	alpha_pulse_sequencer sequencer (
		.clock(clock), .reset(reset), .seq_start(seq_start), .seq_kind(seq_kind),
		.seq_busy(seq_busy), .dreset(dreset), .sync(sync),
		.trig_top(trig_top), .tok_a_in(tok_a_in)
	);

	alpha_readout readout (
		.clock(clock), .reset(reset), .data_a(data_a),
		.data_word(data_word), .header(header), .word_valid(word_valid)
	);

endmodule
